// ==== include/slc3_consts.svh ====
`ifndef SLC3_CONSTS_SVH
`define SLC3_CONSTS_SVH

// Data word width
`define SLC3_WIDTH 16

// Memory is 2**SLC3_ADDR_BITS words
`define SLC3_ADDR_BITS 8

`define SLC3_REGS 8

// Low 12 bits of a PAUSE instruction
`define SLC3_LED_BITS 12

`endif

// ==== design/isa_pkg.sv ====
package isa_pkg;

	// Only the opcodes this core executes
	typedef enum logic [3:0] {
		OpBr    = 4'b0000,
		OpAdd   = 4'b0001,
		OpJsr   = 4'b0100,
		OpAnd   = 4'b0101,
		OpLdr   = 4'b0110,
		OpStr   = 4'b0111,
		OpNot   = 4'b1001,
		OpJmp   = 4'b1100,
		OpPause = 4'b1101
	} opcodeE;

endpackage

// ==== design/control_pkg.sv ====
package control_pkg;

	typedef enum logic [4:0] {
		Halted, PauseIR1, PauseIR2,
		S00, S01, S04, S05, S06, S07, S09, S12,
		S16_1, S16_2, S16_3,
		S18, S21, S22, S23,
		S25_1, S25_2, S27,
		S32, S33_1, S33_2, S35
	} stateE;

	typedef enum logic [1:0] {Add, And, Not, PassA} aluOpE;

	typedef enum logic [1:0] {PcInc, PcBus, PcAdder} pcSelE;

	// Second adder operand
	typedef enum logic [1:0] {Addr2Zero, Addr2Off6, Addr2Off9, Addr2Off11} addr2SelE;

endpackage

// ==== design/isdu.sv ====
`timescale 1ns/10ps

module isdu (
	input logic Clk,
	input logic rstN,
	input logic Run,
	input logic Continue,
	input isa_pkg::opcodeE Opcode,
	input logic Ir5,
	input logic Ir11,
	input logic Ben,
	output logic LdMar,
	output logic LdMdr,
	output logic LdIr,
	output logic LdBen,
	output logic LdCc,
	output logic LdReg,
	output logic LdPc,
	output logic LdLed,
	output logic GatePc,
	output logic GateMdr,
	output logic GateAlu,
	output logic GateMarmux,
	output control_pkg::pcSelE PcMux,
	output logic DrMux,
	output logic Sr1Mux,
	output logic Sr2Mux,
	output logic Addr1Mux,
	output control_pkg::addr2SelE Addr2Mux,
	output control_pkg::aluOpE Aluk,
	output logic MemOe,
	output logic MemWe
);
	import isa_pkg::*;
	import control_pkg::*;

	stateE state;
	stateE nextState;

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
			state <= Halted;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			Halted: if (Run) nextState = S18;
			PauseIR1: if (Continue) nextState = PauseIR2;
			PauseIR2: if (!Continue) nextState = S18;
			S18: nextState = S33_1;
			S33_1: nextState = S33_2;
			S33_2: nextState = S35;
			S35: nextState = S32;
			S32:
				case (Opcode)
					OpBr: nextState = S00;
					OpAdd: nextState = S01;
					OpJsr: nextState = S04;
					OpAnd: nextState = S05;
					OpLdr: nextState = S06;
					OpStr: nextState = S07;
					OpNot: nextState = S09;
					OpJmp: nextState = S12;
					OpPause: nextState = PauseIR1;
					default: nextState = S18; // Unsupported, skip it
				endcase
			S00: nextState = Ben ? S22 : S18;
			S04: nextState = S21;
			S06: nextState = S25_1;
			S25_1: nextState = S25_2;
			S25_2: nextState = S27;
			S07: nextState = S23;
			S23: nextState = S16_1;
			S16_1: nextState = S16_2;
			S16_2: nextState = S16_3;
			default: nextState = S18; // Single-cycle execute states
		endcase
	end

	always_comb
	begin
		LdMar = 1'b0;
		LdMdr = 1'b0;
		LdIr = 1'b0;
		LdBen = 1'b0;
		LdCc = 1'b0;
		LdReg = 1'b0;
		LdPc = 1'b0;
		LdLed = 1'b0;
		GatePc = 1'b0;
		GateMdr = 1'b0;
		GateAlu = 1'b0;
		GateMarmux = 1'b0;
		PcMux = PcInc;
		DrMux = 1'b0;
		Sr1Mux = 1'b0;
		Sr2Mux = 1'b0;
		Addr1Mux = 1'b0;
		Addr2Mux = Addr2Zero;
		Aluk = Add;
		MemOe = 1'b1;
		MemWe = 1'b1;
		case (state)
			PauseIR1, PauseIR2: LdLed = 1'b1;
			S18:
			begin
				GatePc = 1'b1;
				LdMar = 1'b1;
				LdPc = 1'b1;
			end
			S33_1: MemOe = 1'b0;
			S33_2, S25_2:
			begin
				MemOe = 1'b0;
				LdMdr = 1'b1; // Data valid on second read cycle
			end
			S25_1: MemOe = 1'b0;
			S35:
			begin
				GateMdr = 1'b1;
				LdIr = 1'b1;
			end
			S32: LdBen = 1'b1;
			S01, S05, S09:
			begin
				Sr1Mux = 1'b1;
				Sr2Mux = Ir5;
				Aluk = (state == S01) ? Add : (state == S05) ? And : Not;
				GateAlu = 1'b1;
				LdReg = 1'b1;
				LdCc = 1'b1;
			end
			S04:
			begin
				GatePc = 1'b1;
				DrMux = 1'b1; // Return address into R7
				LdReg = 1'b1;
			end
			S21:
			begin
				Addr2Mux = Addr2Off11;
				PcMux = PcAdder;
				LdPc = 1'b1;
			end
			S22:
			begin
				Addr2Mux = Addr2Off9;
				PcMux = PcAdder;
				LdPc = 1'b1;
			end
			S12:
			begin
				Sr1Mux = 1'b1;
				Addr1Mux = 1'b1;
				PcMux = PcAdder;
				LdPc = 1'b1;
			end
			S06, S07:
			begin
				Sr1Mux = 1'b1;
				Addr1Mux = 1'b1;
				Addr2Mux = Addr2Off6;
				GateMarmux = 1'b1;
				LdMar = 1'b1;
			end
			S27:
			begin
				GateMdr = 1'b1;
				LdReg = 1'b1;
				LdCc = 1'b1;
			end
			S23:
			begin
				Aluk = PassA; // SR from IR[11:9]
				GateAlu = 1'b1;
				LdMdr = 1'b1;
			end
			S16_1, S16_2, S16_3: MemWe = 1'b0;
			default: ;
		endcase
	end
endmodule

// ==== design/datapath.sv ====
`timescale 1ns/10ps
`include "slc3_consts.svh"

module datapath (
	input logic Clk,
	input logic rstN,
	input logic LdMar,
	input logic LdMdr,
	input logic LdIr,
	input logic LdBen,
	input logic LdCc,
	input logic LdReg,
	input logic LdPc,
	input logic LdLed,
	input logic GatePc,
	input logic GateMdr,
	input logic GateAlu,
	input logic GateMarmux,
	input control_pkg::pcSelE PcMux,
	input logic DrMux,
	input logic Sr1Mux,
	input logic Sr2Mux,
	input logic Addr1Mux,
	input control_pkg::addr2SelE Addr2Mux,
	input control_pkg::aluOpE Aluk,
	input logic MemOe,
	input logic [`SLC3_WIDTH-1:0] MemRdData,
	output logic [`SLC3_ADDR_BITS-1:0] Mar,
	output logic [`SLC3_WIDTH-1:0] Mdr,
	output isa_pkg::opcodeE Opcode,
	output logic Ir5,
	output logic Ir11,
	output logic Ben,
	output logic [`SLC3_LED_BITS-1:0] Led
);
	import isa_pkg::*;
	import control_pkg::*;

	localparam int W = `SLC3_WIDTH;
	localparam int RegIdxBits = $clog2(`SLC3_REGS);

	logic [W-1:0] pc;
	logic [W-1:0] ir;
	logic [W-1:0] bus;
	logic [W-1:0] sr1Val;
	logic [W-1:0] aluB;
	logic [W-1:0] aluOut;
	logic [W-1:0] addr2Val;
	logic [W-1:0] adderOut;
	logic [W-1:0] pcNext;
	logic [W-1:0] regFile [`SLC3_REGS];
	logic [RegIdxBits-1:0] drIdx;
	logic [2:0] nzp;

	assign drIdx = DrMux ? RegIdxBits'(7) : ir[11:9];
	assign sr1Val = regFile[Sr1Mux ? ir[8:6] : ir[11:9]];
	assign aluB = Sr2Mux ? W'($signed(ir[4:0])) : regFile[ir[2:0]];

	always_comb
	begin
		case (Aluk)
			Add: aluOut = sr1Val + aluB;
			And: aluOut = sr1Val & aluB;
			Not: aluOut = ~sr1Val;
			default: aluOut = sr1Val;
		endcase
		case (Addr2Mux)
			Addr2Off6: addr2Val = W'($signed(ir[5:0]));
			Addr2Off9: addr2Val = W'($signed(ir[8:0]));
			Addr2Off11: addr2Val = W'($signed(ir[10:0]));
			default: addr2Val = '0;
		endcase
		adderOut = (Addr1Mux ? sr1Val : pc) + addr2Val;
	end

	always_comb
	begin
		case (PcMux)
			PcBus: pcNext = bus;
			PcAdder: pcNext = adderOut;
			default: pcNext = pc + W'(1);
		endcase
	end

	// At most one gate is active per state
	assign bus = ({W{GatePc}} & pc) | ({W{GateMdr}} & Mdr) |
		({W{GateAlu}} & aluOut) | ({W{GateMarmux}} & adderOut);

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= '0;
			ir <= '0;
			Mar <= '0;
			nzp <= '0;
			Ben <= 1'b0;
			Led <= '0;
		end
		else
		begin
			if (LdPc) pc <= pcNext;
			if (LdIr) ir <= bus;
			if (LdMar) Mar <= bus[`SLC3_ADDR_BITS-1:0];
			if (LdCc) nzp <= {bus[W-1], bus == '0, !bus[W-1] && bus != '0};
			if (LdBen) Ben <= |(ir[11:9] & nzp);
			if (LdLed) Led <= ir[`SLC3_LED_BITS-1:0];
		end
	end

	always_ff @(posedge Clk)
	begin
		if (LdMdr) Mdr <= MemOe ? bus : MemRdData; // Memory while reading
		if (LdReg) regFile[drIdx] <= bus;
	end

	assign Opcode = opcodeE'(ir[15:12]);
	assign Ir5 = ir[5];
	assign Ir11 = ir[11];
endmodule

// ==== design/wordMemory.sv ====
`timescale 1ns/10ps
`include "slc3_consts.svh"

module wordMemory (
	input logic Clk,
	input logic [`SLC3_ADDR_BITS-1:0] Addr,
	input logic [`SLC3_WIDTH-1:0] WrData,
	input logic MemOe,
	input logic MemWe,
	input logic LoadWe,
	input logic [`SLC3_ADDR_BITS-1:0] LoadAddr,
	input logic [`SLC3_WIDTH-1:0] LoadData,
	output logic [`SLC3_WIDTH-1:0] RdData,
	output logic [`SLC3_WIDTH-1:0] LoadRdData
);
	localparam int Depth = 1 << `SLC3_ADDR_BITS;

	logic [`SLC3_WIDTH-1:0] mem [Depth];

	always_ff @(posedge Clk)
	begin
		if (!MemWe) mem[Addr] <= WrData;
		if (LoadWe) mem[LoadAddr] <= LoadData; // Load port wins a collision
		if (!MemOe) RdData <= mem[Addr];
		LoadRdData <= mem[LoadAddr];
	end
endmodule

// ==== design/slc3.sv ====
`timescale 1ns/10ps
`include "slc3_consts.svh"

module slc3 (
	input logic Clk,
	input logic rstN,
	input logic Run,
	input logic Continue,
	input logic LoadWe,
	input logic [`SLC3_ADDR_BITS-1:0] LoadAddr,
	input logic [`SLC3_WIDTH-1:0] LoadData,
	output logic [`SLC3_WIDTH-1:0] LoadRdData,
	output logic [`SLC3_LED_BITS-1:0] Led,
	output logic Paused
);
	import isa_pkg::*;
	import control_pkg::*;

	logic LdMar, LdMdr, LdIr, LdBen, LdCc, LdReg, LdPc, LdLed;
	logic GatePc, GateMdr, GateAlu, GateMarmux;
	logic DrMux, Sr1Mux, Sr2Mux, Addr1Mux;
	logic MemOe, MemWe;
	logic Ir5, Ir11, Ben;
	pcSelE PcMux;
	addr2SelE Addr2Mux;
	aluOpE Aluk;
	opcodeE Opcode;
	logic [`SLC3_ADDR_BITS-1:0] Mar;
	logic [`SLC3_WIDTH-1:0] Mdr;
	logic [`SLC3_WIDTH-1:0] MemRdData;

	isdu i_isdu (.*);

	datapath i_datapath (.*);

	wordMemory i_wordMemory (.Addr(Mar), .WrData(Mdr), .RdData(MemRdData), .*);

	assign Paused = LdLed; // LED load only happens in the pause states
endmodule

// ==== test/isdu_properties.sv ====
`timescale 1ns/10ps

module isduProperties (
	input logic Clk,
	input logic rstN,
	input logic Continue,
	input control_pkg::stateE state,
	input logic LdMar,
	input logic LdMdr,
	input logic LdIr,
	input logic LdBen,
	input logic LdCc,
	input logic LdReg,
	input logic LdPc,
	input logic LdLed,
	input logic GatePc,
	input logic GateMdr,
	input logic GateAlu,
	input logic GateMarmux,
	input logic MemOe
);
	import control_pkg::*;

	logic anyLoad;
	int failCount = 0;

	assign anyLoad = LdMar | LdMdr | LdIr | LdBen | LdCc | LdReg | LdPc | LdLed;

	busGate: assert property (@(posedge Clk) disable iff (!rstN)
		$onehot0({GatePc, GateMdr, GateAlu, GateMarmux}))
	else
	begin
		failCount++;
		$error("More than one bus gate high");
	end

	resetLoads: assert property (@(posedge Clk) !rstN |-> !anyLoad)
	else
	begin
		failCount++;
		$error("Load enable high during reset");
	end

	// IR takes the word after S33_1 and S33_2
	fetchRead: assert property (@(posedge Clk) disable iff (!rstN)
		LdIr |-> ($past(!MemOe) && $past(!MemOe, 2)))
	else
	begin
		failCount++;
		$error("IR loaded without a two-cycle memory read");
	end

	pauseHold: assert property (@(posedge Clk) disable iff (!rstN)
		(state == PauseIR1 && !Continue) |=> state == PauseIR1)
	else
	begin
		failCount++;
		$error("Left PauseIR1 before Continue rose");
	end

	releaseHold: assert property (@(posedge Clk) disable iff (!rstN)
		(state == PauseIR2 && Continue) |=> state == PauseIR2)
	else
	begin
		failCount++;
		$error("Left PauseIR2 before Continue fell");
	end
endmodule

bind isdu isduProperties i_isduProperties (.Clk, .rstN, .Continue, .state,
	.LdMar, .LdMdr, .LdIr, .LdBen, .LdCc, .LdReg, .LdPc, .LdLed,
	.GatePc, .GateMdr, .GateAlu, .GateMarmux, .MemOe);

// ==== test/slc3Checker.sv ====
`timescale 1ns/10ps
`include "slc3_consts.svh"

module slc3Checker (
	input logic Clk,
	input logic [`SLC3_LED_BITS-1:0] Led,
	input logic Paused,
	input logic [`SLC3_WIDTH-1:0] LoadRdData,
	input logic LedCheck,
	input logic [`SLC3_LED_BITS-1:0] LedExp,
	input logic IdleCheck,
	input logic MemCheck,
	input logic [`SLC3_ADDR_BITS-1:0] MemAddr,
	input logic [`SLC3_WIDTH-1:0] MemExp,
	output int LedErrors,
	output int MemErrors
);
	int ledErrs = 0;
	int memErrs = 0;

	// DUT outputs settle between rising edges
	always @(negedge Clk)
	begin
		if (LedCheck && Paused !== 1'b1)
		begin
			$display("Fail %0t: Paused low while Led %h was expected", $time, LedExp);
			ledErrs++;
		end
		else if (LedCheck && Led !== LedExp)
		begin
			$display("Fail %0t: Led is %h, expected %h", $time, Led, LedExp);
			ledErrs++;
		end
		if (IdleCheck && (Paused !== 1'b0 || Led !== '0))
		begin
			$display("Fail %0t: after reset Led %h Paused %b, expected 000 and 0",
				$time, Led, Paused);
			ledErrs++;
		end
		if (MemCheck && LoadRdData !== MemExp)
		begin
			$display("Fail %0t: memory[%h] is %h, expected %h",
				$time, MemAddr, LoadRdData, MemExp);
			memErrs++;
		end
	end

	assign LedErrors = ledErrs;
	assign MemErrors = memErrs;
endmodule

// ==== test/slc3Tb.sv ====
`timescale 1ns/10ps
`include "slc3_consts.svh"

module slc3Tb;
	logic Clk;
	logic rstN;
	logic Run;
	logic Continue;
	logic LoadWe;
	logic [`SLC3_ADDR_BITS-1:0] LoadAddr;
	logic [`SLC3_WIDTH-1:0] LoadData;
	logic [`SLC3_WIDTH-1:0] LoadRdData;
	logic [`SLC3_LED_BITS-1:0] Led;
	logic Paused;
	logic LedCheck;
	logic [`SLC3_LED_BITS-1:0] LedExp;
	logic IdleCheck;
	logic MemCheck;
	logic [`SLC3_WIDTH-1:0] MemExp;
	int LedErrors;
	int MemErrors;
	int fileErrors = 0;
	int cycles = 0;
	int cycleLimit = 200;
	byte cmds[$];
	logic [`SLC3_WIDTH-1:0] argA[$];
	logic [`SLC3_WIDTH-1:0] argB[$];

	slc3 i_slc3 (.*);

	slc3Checker i_checker (.MemAddr(LoadAddr), .*);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	always @(posedge Clk)
	begin
		if (cycles >= cycleLimit)
		begin
			$display("Run timed out after %0d cycles", cycles);
			$display("Test failures found");
			$finish;
		end
		else
			cycles <= cycles + 1;
	end

	task automatic readCases(input int fd);
		string line;
		logic [`SLC3_WIDTH-1:0] a;
		logic [`SLC3_WIDTH-1:0] b;
		int n;
		while ($fgets(line, fd) > 0)
		begin
			if (line.len() > 1 && line.getc(0) != "#") // Skip blanks and comments
			begin
				a = '0;
				b = '0;
				n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
				cmds.push_back(line.getc(0));
				argA.push_back(a);
				argB.push_back(b);
			end
		end
		$fclose(fd);
	endtask

	task automatic applyReset();
		@(posedge Clk);
		rstN <= 1'b0;
		Run <= 1'b0;
		Continue <= 1'b0;
		LoadWe <= 1'b0;
		repeat (8) @(posedge Clk);
		rstN <= 1'b1;
		@(posedge Clk);
		IdleCheck <= 1'b1; // Led and Paused must be clear
		@(posedge Clk);
		IdleCheck <= 1'b0;
	endtask

	task automatic preloadWord(input logic [`SLC3_ADDR_BITS-1:0] addr,
		input logic [`SLC3_WIDTH-1:0] data);
		@(posedge Clk);
		LoadWe <= 1'b1;
		LoadAddr <= addr;
		LoadData <= data;
		@(posedge Clk);
		LoadWe <= 1'b0;
	endtask

	task automatic pulseRun();
		@(posedge Clk);
		Run <= 1'b1;
		@(posedge Clk);
		Run <= 1'b0;
	endtask

	task automatic pulseContinue();
		@(posedge Clk);
		Continue <= 1'b1;
		@(posedge Clk);
		Continue <= 1'b0;
		@(negedge Clk);
		while (Paused)
			@(negedge Clk);
	endtask

	task automatic expectLed(input logic [`SLC3_LED_BITS-1:0] value);
		@(negedge Clk);
		while (!Paused)
			@(negedge Clk);
		// LED register loads one cycle into the pause
		@(posedge Clk);
		LedExp <= value;
		LedCheck <= 1'b1;
		@(posedge Clk);
		LedCheck <= 1'b0;
	endtask

	task automatic expectWord(input logic [`SLC3_ADDR_BITS-1:0] addr,
		input logic [`SLC3_WIDTH-1:0] data);
		@(posedge Clk);
		LoadAddr <= addr;
		@(posedge Clk); // Readback port has one cycle of latency
		MemExp <= data;
		MemCheck <= 1'b1;
		@(posedge Clk);
		MemCheck <= 1'b0;
	endtask

	task automatic runCases();
		for (int i = 0; i < cmds.size(); i++)
		begin
			case (cmds[i])
				"P": preloadWord(argA[i][`SLC3_ADDR_BITS-1:0], argB[i]);
				"R": pulseRun();
				"L": expectLed(argA[i][`SLC3_LED_BITS-1:0]);
				"M": expectWord(argA[i][`SLC3_ADDR_BITS-1:0], argB[i]);
				"C": pulseContinue();
				"X": applyReset();
				default:
				begin
					$display("Unknown command %c in case entry %0d", cmds[i], i + 1);
					fileErrors++;
				end
			endcase
		end
	endtask

	initial
	begin
		int fd;
		int assertFails;
		rstN <= 1'b0;
		Run <= 1'b0;
		Continue <= 1'b0;
		LoadWe <= 1'b0;
		LoadAddr <= '0;
		LoadData <= '0;
		LedCheck <= 1'b0;
		LedExp <= '0;
		IdleCheck <= 1'b0;
		MemCheck <= 1'b0;
		MemExp <= '0;
		fd = $fopen("test/slc3_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the case file test/slc3_cases.txt");
			$display("Test failures found");
			$finish;
		end
		else
		begin
			readCases(fd);
			cycleLimit = 80 * cmds.size() + 200;
			applyReset();
			runCases();
			assertFails = i_slc3.i_isdu.i_isduProperties.failCount;
			$display("Errors: %0d led or pause, %0d memory, %0d case file, %0d assertion",
				LedErrors, MemErrors, fileErrors, assertFails);
			if (LedErrors + MemErrors + fileErrors + assertFails == 0)
				$display("All tests passed!");
			else
				$display("Test failures found");
			$finish;
		end
	end
endmodule

// ==== verilog.f ====
+incdir+include
design/isa_pkg.sv
design/control_pkg.sv
design/isdu.sv
design/datapath.sv
design/wordMemory.sv
design/slc3.sv
test/isdu_properties.sv
test/slc3Checker.sv
test/slc3Tb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log build.log
verilator --binary --timing --assert --timescale 1ns/10ps -f verilog.f \
	--top-module slc3Tb -o slc3Sim > build.log 2>&1 &&
	./obj_dir/slc3Sim > sim.log 2>&1
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== test/slc3_cases.txt ====
# Command letter, then hex operands: P addr data, R, L led, M addr data, C, X
# P preloads a word, R pulses Run, L waits for a pause, M reads back, C continues, X resets
# ALU ops, stored results, two pauses, memory untouched before Run
P 00 5020
P 01 1227
P 02 147D
P 03 1642
P 04 58E6
P 05 9AFF
P 06 7610
P 07 7811
P 08 7A12
P 09 D0A1
P 0A 7414
P 0B D0A2
P 14 1234
M 14 1234
R
L 0A1
M 14 1234
C
L 0A2
M 10 000B
M 11 0002
M 12 FFF4
M 14 0004
X
# LDR through a loaded pointer, STR at signed offsets
P 00 5020
P 01 621F
P 02 647E
P 03 7445
P 04 6641
P 05 7678
P 06 D0B2
P 1F 0040
P 3E BEEF
P 41 8001
R
L 0B2
M 45 BEEF
M 38 8001
X
# Branches on ALU and load flags, skipped stores all aim at 11
P 00 5020
P 01 1221
P 02 0401
P 03 7210
P 04 0201
P 05 7211
P 06 143B
P 07 0C01
P 08 7211
P 09 0601
P 0A 7413
P 0B 6614
P 0C 0401
P 0D 7211
P 0E D0C3
P 11 5555
P 14 0000
R
L 0C3
M 10 0001
M 11 5555
M 13 FFFB
X
# JSR to 05, return through JMP R7, then store R7
P 00 5020
P 01 4803
P 02 7E10
P 03 D0D4
P 05 1227
P 06 7211
P 07 C1C0
R
L 0D4
M 10 0002
M 11 0007
